//--- rtl/rvIsaPkg.sv
// RV32 ISA constants: widths, base and M-extension opcodes, funct codes
package rvIsaPkg;

    // Architectural widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;

    // Major opcodes handled by decode
    typedef enum logic [OPCODE_W-1:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    // funct7 groups for OP
    localparam logic [FUNCT7_W-1:0] FUNCT7_BASE   = 7'b0000000;
    localparam logic [FUNCT7_W-1:0] FUNCT7_ALT    = 7'b0100000;
    localparam logic [FUNCT7_W-1:0] FUNCT7_MULDIV = 7'b0000001;

    // funct3 of the integer ALU group
    localparam logic [FUNCT3_W-1:0] FUNCT3_ADD  = 3'b000;
    localparam logic [FUNCT3_W-1:0] FUNCT3_SLL  = 3'b001;
    localparam logic [FUNCT3_W-1:0] FUNCT3_SLT  = 3'b010;
    localparam logic [FUNCT3_W-1:0] FUNCT3_SLTU = 3'b011;
    localparam logic [FUNCT3_W-1:0] FUNCT3_XOR  = 3'b100;
    localparam logic [FUNCT3_W-1:0] FUNCT3_SR   = 3'b101;
    localparam logic [FUNCT3_W-1:0] FUNCT3_OR   = 3'b110;
    localparam logic [FUNCT3_W-1:0] FUNCT3_AND  = 3'b111;

    // funct3 of the M extension
    localparam logic [FUNCT3_W-1:0] FUNCT3_MUL    = 3'b000;
    localparam logic [FUNCT3_W-1:0] FUNCT3_MULH   = 3'b001;
    localparam logic [FUNCT3_W-1:0] FUNCT3_MULHSU = 3'b010;
    localparam logic [FUNCT3_W-1:0] FUNCT3_MULHU  = 3'b011;
    localparam logic [FUNCT3_W-1:0] FUNCT3_DIV    = 3'b100;
    localparam logic [FUNCT3_W-1:0] FUNCT3_DIVU   = 3'b101;
    localparam logic [FUNCT3_W-1:0] FUNCT3_REM    = 3'b110;
    localparam logic [FUNCT3_W-1:0] FUNCT3_REMU   = 3'b111;

endpackage

//--- rtl/decodeCtrlPkg.sv
// Decode control types: ALU operations, instruction classes, immediate formats, branches
package decodeCtrlPkg;

    // ALU operation select, encoding shared with the execute stage
    typedef enum logic [4:0] {
        ALU_AND    = 5'b00000,
        ALU_OR     = 5'b00001,
        ALU_ADD    = 5'b00010,
        ALU_XOR    = 5'b00011,
        ALU_SUB    = 5'b00100,
        ALU_SLL    = 5'b00110,
        ALU_SRL    = 5'b00111,
        ALU_SRA    = 5'b01000,
        ALU_SLT    = 5'b01001,
        ALU_SLTU   = 5'b01010,
        ALU_MUL    = 5'b01011,
        ALU_MULH   = 5'b01100,
        ALU_MULHSU = 5'b01101,
        ALU_MULHU  = 5'b01110,
        ALU_DIV    = 5'b01111,
        ALU_DIVU   = 5'b10000,
        ALU_REM    = 5'b10001,
        ALU_REMU   = 5'b10010
    } aluCtrl_e;

    // Instruction class seen by the ALU decoder
    typedef enum logic [2:0] {
        ALUOP_MEMORY = 3'b000,
        ALUOP_BRANCH = 3'b001,
        ALUOP_ARITH  = 3'b010,
        ALUOP_JUMP   = 3'b011,
        ALUOP_LUI    = 3'b100,
        ALUOP_AUIPC  = 3'b101,
        ALUOP_JALR   = 3'b111
    } aluOp_e;

    // Immediate format
    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5
    } immSel_e;

    // Branch condition, same values as the branch funct3
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branchType_e;

endpackage

//--- rtl/decodeRegister.sv
// Decode pipeline register for instruction word, operand values and valid
`timescale 1ns/10ps

module decodeRegister (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [rvIsaPkg::XLEN-1:0] instrIn,
    input  logic                      instrValid,
    input  logic [rvIsaPkg::XLEN-1:0] rsValue1In,
    input  logic [rvIsaPkg::XLEN-1:0] rsValue2In,
    output logic [rvIsaPkg::XLEN-1:0] regInstr,
    output logic                      regValid,
    output logic [rvIsaPkg::XLEN-1:0] regValue1,
    output logic [rvIsaPkg::XLEN-1:0] regValue2
);

    // No stall, so every edge takes a new instruction
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            regInstr  <= '0;
            regValid  <= 1'b0;
            regValue1 <= '0;
            regValue2 <= '0;
        end
        else
        begin
            regInstr  <= instrIn;
            regValid  <= instrValid;
            regValue1 <= rsValue1In;
            regValue2 <= rsValue2In;
        end
    end

endmodule

//--- rtl/mainControl.sv
// Main control: opcode to memory, write-back, source and immediate controls plus illegal flag
`timescale 1ns/10ps

module mainControl (
    input  logic [rvIsaPkg::XLEN-1:0] regInstr,
    input  logic                      regValid,
    output logic                      memWrite,
    output logic                      memRead,
    output logic                      regWrite,
    output logic                      aluSrc,
    output logic                      memToReg,
    output logic                      pcSrc,
    output logic                      illegal,
    output decodeCtrlPkg::aluOp_e     aluOp,
    output decodeCtrlPkg::immSel_e    immSel
);

    logic [rvIsaPkg::OPCODE_W-1:0] opcode;

    assign opcode = regInstr[rvIsaPkg::OPCODE_W-1:0];

    always_comb
    begin
        memWrite = 1'b0;
        memRead  = 1'b0;
        regWrite = 1'b0;
        aluSrc   = 1'b0;
        memToReg = 1'b0;
        pcSrc    = 1'b0;
        illegal  = 1'b0;
        aluOp    = decodeCtrlPkg::ALUOP_MEMORY;
        immSel   = decodeCtrlPkg::IMM_NONE;
        // Bubble cycles leave everything at zero
        if (regValid)
        begin
            case (opcode)
                rvIsaPkg::OP_LUI, rvIsaPkg::OP_AUIPC:
                begin
                    regWrite = 1'b1;
                    aluSrc   = 1'b1;
                    immSel   = decodeCtrlPkg::IMM_U;
                    aluOp    = (opcode == rvIsaPkg::OP_LUI) ? decodeCtrlPkg::ALUOP_LUI
                                                            : decodeCtrlPkg::ALUOP_AUIPC;
                end
                rvIsaPkg::OP_JAL, rvIsaPkg::OP_JALR:
                begin
                    // Link register gets pc + 4
                    regWrite = 1'b1;
                    pcSrc    = 1'b1;
                    aluSrc   = 1'b1;
                    if (opcode == rvIsaPkg::OP_JAL)
                    begin
                        aluOp  = decodeCtrlPkg::ALUOP_JUMP;
                        immSel = decodeCtrlPkg::IMM_J;
                    end
                    else
                    begin
                        aluOp  = decodeCtrlPkg::ALUOP_JALR;
                        immSel = decodeCtrlPkg::IMM_I;
                    end
                end
                rvIsaPkg::OP_BRANCH:
                begin
                    pcSrc  = 1'b1;
                    aluOp  = decodeCtrlPkg::ALUOP_BRANCH;
                    immSel = decodeCtrlPkg::IMM_B;
                end
                rvIsaPkg::OP_LOAD:
                begin
                    memRead  = 1'b1;
                    memToReg = 1'b1;
                    regWrite = 1'b1;
                    aluSrc   = 1'b1;
                    immSel   = decodeCtrlPkg::IMM_I;
                end
                rvIsaPkg::OP_STORE:
                begin
                    memWrite = 1'b1;
                    aluSrc   = 1'b1;
                    immSel   = decodeCtrlPkg::IMM_S;
                end
                rvIsaPkg::OP_IMM:
                begin
                    regWrite = 1'b1;
                    aluSrc   = 1'b1;
                    aluOp    = decodeCtrlPkg::ALUOP_ARITH;
                    immSel   = decodeCtrlPkg::IMM_I;
                end
                rvIsaPkg::OP_REG:
                begin
                    regWrite = 1'b1;
                    aluOp    = decodeCtrlPkg::ALUOP_ARITH;
                end
                default:
                    illegal = 1'b1;
            endcase
        end
    end

endmodule

//--- rtl/immGen.sv
// Immediate generator: assembles and sign-extends the I, S, B, U and J formats
`timescale 1ns/10ps

module immGen (
    input  logic [rvIsaPkg::XLEN-1:0] regInstr,
    input  decodeCtrlPkg::immSel_e    immSel,
    output logic [rvIsaPkg::XLEN-1:0] imm
);

    logic signBit;

    // Bit 31 is the sign in every format
    assign signBit = regInstr[31];

    always_comb
    begin
        case (immSel)
            decodeCtrlPkg::IMM_I:
                imm = {{20{signBit}}, regInstr[31:20]};
            decodeCtrlPkg::IMM_S:
                imm = {{20{signBit}}, regInstr[31:25], regInstr[11:7]};
            decodeCtrlPkg::IMM_B:
                imm = {{19{signBit}}, signBit, regInstr[7], regInstr[30:25],
                       regInstr[11:8], 1'b0};
            // Upper 20 bits, low half cleared
            decodeCtrlPkg::IMM_U:
                imm = {regInstr[31:12], 12'b0};
            decodeCtrlPkg::IMM_J:
                imm = {{11{signBit}}, signBit, regInstr[19:12], regInstr[20],
                       regInstr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

//--- rtl/aluControl.sv
// ALU control: instruction class, funct3 and funct7 to ALU operation and branch kind
`timescale 1ns/10ps

module aluControl (
    input  logic [rvIsaPkg::XLEN-1:0]   regInstr,
    input  logic                        regValid,
    input  decodeCtrlPkg::aluOp_e       aluOp,
    output decodeCtrlPkg::aluCtrl_e     aluCtrl,
    output decodeCtrlPkg::branchType_e  branchType
);

    logic [rvIsaPkg::FUNCT3_W-1:0] funct3;
    logic [rvIsaPkg::FUNCT7_W-1:0] funct7;
    logic                          isReg;

    assign funct3 = regInstr[14:12];
    assign funct7 = regInstr[31:25];
    assign isReg  = (regInstr[rvIsaPkg::OPCODE_W-1:0] == rvIsaPkg::OP_REG);

    always_comb
    begin
        aluCtrl    = decodeCtrlPkg::ALU_AND;
        branchType = decodeCtrlPkg::BR_BEQ;
        if (regValid)
        begin
            aluCtrl = decodeCtrlPkg::ALU_ADD;
            case (aluOp)
                // Compare by subtraction
                decodeCtrlPkg::ALUOP_BRANCH:
                begin
                    aluCtrl    = decodeCtrlPkg::ALU_SUB;
                    branchType = decodeCtrlPkg::branchType_e'(funct3);
                end
                decodeCtrlPkg::ALUOP_ARITH:
                begin
                    if (isReg && funct7 == rvIsaPkg::FUNCT7_MULDIV)
                    begin
                        case (funct3)
                            rvIsaPkg::FUNCT3_MUL:    aluCtrl = decodeCtrlPkg::ALU_MUL;
                            rvIsaPkg::FUNCT3_MULH:   aluCtrl = decodeCtrlPkg::ALU_MULH;
                            rvIsaPkg::FUNCT3_MULHSU: aluCtrl = decodeCtrlPkg::ALU_MULHSU;
                            rvIsaPkg::FUNCT3_MULHU:  aluCtrl = decodeCtrlPkg::ALU_MULHU;
                            rvIsaPkg::FUNCT3_DIV:    aluCtrl = decodeCtrlPkg::ALU_DIV;
                            rvIsaPkg::FUNCT3_DIVU:   aluCtrl = decodeCtrlPkg::ALU_DIVU;
                            rvIsaPkg::FUNCT3_REM:    aluCtrl = decodeCtrlPkg::ALU_REM;
                            default:                 aluCtrl = decodeCtrlPkg::ALU_REMU;
                        endcase
                    end
                    else if (isReg && funct7 == rvIsaPkg::FUNCT7_ALT)
                    begin
                        // Only SUB and SRA exist in the alternate group
                        if (funct3 == rvIsaPkg::FUNCT3_ADD)
                            aluCtrl = decodeCtrlPkg::ALU_SUB;
                        else if (funct3 == rvIsaPkg::FUNCT3_SR)
                            aluCtrl = decodeCtrlPkg::ALU_SRA;
                    end
                    else if (!isReg || funct7 == rvIsaPkg::FUNCT7_BASE)
                    begin
                        // OP-IMM ignores funct7 except for the right shifts
                        case (funct3)
                            rvIsaPkg::FUNCT3_SLL:  aluCtrl = decodeCtrlPkg::ALU_SLL;
                            rvIsaPkg::FUNCT3_SLT:  aluCtrl = decodeCtrlPkg::ALU_SLT;
                            rvIsaPkg::FUNCT3_SLTU: aluCtrl = decodeCtrlPkg::ALU_SLTU;
                            rvIsaPkg::FUNCT3_XOR:  aluCtrl = decodeCtrlPkg::ALU_XOR;
                            rvIsaPkg::FUNCT3_OR:   aluCtrl = decodeCtrlPkg::ALU_OR;
                            rvIsaPkg::FUNCT3_AND:  aluCtrl = decodeCtrlPkg::ALU_AND;
                            rvIsaPkg::FUNCT3_SR:
                            begin
                                if (funct7 == rvIsaPkg::FUNCT7_BASE)
                                    aluCtrl = decodeCtrlPkg::ALU_SRL;
                                else if (funct7 == rvIsaPkg::FUNCT7_ALT)
                                    aluCtrl = decodeCtrlPkg::ALU_SRA;
                            end
                            default:               aluCtrl = decodeCtrlPkg::ALU_ADD;
                        endcase
                    end
                end
                // Address and link arithmetic all use ADD
                default:
                    aluCtrl = decodeCtrlPkg::ALU_ADD;
            endcase
        end
    end

endmodule

//--- rtl/decodeTop.sv
// Decode stage top: pipeline register feeding control, immediate and ALU decoders
`timescale 1ns/10ps

module decodeTop (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [rvIsaPkg::XLEN-1:0]           instrIn,
    input  logic                                instrValid,
    input  logic [rvIsaPkg::XLEN-1:0]           rsValue1In,
    input  logic [rvIsaPkg::XLEN-1:0]           rsValue2In,
    output logic [rvIsaPkg::REG_ADDR_W-1:0]     rs1,
    output logic [rvIsaPkg::REG_ADDR_W-1:0]     rs2,
    output logic [rvIsaPkg::REG_ADDR_W-1:0]     rd,
    output logic [rvIsaPkg::XLEN-1:0]           imm,
    output logic [rvIsaPkg::XLEN-1:0]           value1,
    output logic [rvIsaPkg::XLEN-1:0]           value2,
    output logic                                decValid,
    output logic                                memWrite,
    output logic                                memRead,
    output logic                                regWrite,
    output logic                                aluSrc,
    output logic                                memToReg,
    output logic                                pcSrc,
    output logic                                illegal,
    output decodeCtrlPkg::aluOp_e               aluOp,
    output decodeCtrlPkg::aluCtrl_e             aluCtrl,
    output decodeCtrlPkg::branchType_e          branchType
);

    logic [rvIsaPkg::XLEN-1:0] regInstr;
    logic                      regValid;
    decodeCtrlPkg::immSel_e    immSel;

    // Register fields straight from the stored instruction
    assign rs1      = regInstr[19:15];
    assign rs2      = regInstr[24:20];
    assign rd       = regInstr[11:7];
    assign decValid = regValid;

    decodeRegister uReg (
        .clk        (clk),
        .rst        (rst),
        .instrIn    (instrIn),
        .instrValid (instrValid),
        .rsValue1In (rsValue1In),
        .rsValue2In (rsValue2In),
        .regInstr   (regInstr),
        .regValid   (regValid),
        .regValue1  (value1),
        .regValue2  (value2)
    );

    mainControl uMainCtrl (
        .regInstr (regInstr),
        .regValid (regValid),
        .memWrite (memWrite),
        .memRead  (memRead),
        .regWrite (regWrite),
        .aluSrc   (aluSrc),
        .memToReg (memToReg),
        .pcSrc    (pcSrc),
        .illegal  (illegal),
        .aluOp    (aluOp),
        .immSel   (immSel)
    );

    immGen uImmGen (
        .regInstr (regInstr),
        .immSel   (immSel),
        .imm      (imm)
    );

    aluControl uAluCtrl (
        .regInstr   (regInstr),
        .regValid   (regValid),
        .aluOp      (aluOp),
        .aluCtrl    (aluCtrl),
        .branchType (branchType)
    );

endmodule

//--- sim/decodeTop_props.sv
// Decode stage assertions: memory exclusivity, quiet bubbles and isolated illegal flag
`timescale 1ns/10ps

module decodeTopProps (
    input logic clk,
    input logic rst,
    input logic decValid,
    input logic memWrite,
    input logic memRead,
    input logic regWrite,
    input logic aluSrc,
    input logic memToReg,
    input logic pcSrc,
    input logic illegal
);

    logic otherCtrl;

    assign otherCtrl = memWrite | memRead | regWrite | aluSrc | memToReg | pcSrc;

    // A load and a store never issue together
    assert property (@(posedge clk) !(memRead && memWrite))
        else $error("memRead and memWrite are high together");

    // Bubbles carry no control, reset included
    assert property (@(posedge clk) !decValid |-> !(otherCtrl || illegal))
        else $error("control active while decValid is low");

    assert property (@(posedge clk) disable iff (rst) illegal |-> !otherCtrl)
        else $error("illegal raised together with another control");

endmodule

bind decodeTop decodeTopProps uProps (.*);

//--- sim/decodeTb.sv
// Decode stage testbench with a table of instructions and expected decode, checked cycle by cycle
`timescale 1ns/10ps

module decodeTb;

    localparam int RESET_CYCLES = 16;
    localparam int MARGIN       = 20;

    // Bit order is decValid, memWrite, memRead, regWrite, aluSrc, memToReg, pcSrc, illegal
    localparam logic [7:0] CTRL_IDLE    = 8'b0000_0000;
    localparam logic [7:0] CTRL_WR_IMM  = 8'b1001_1000;
    localparam logic [7:0] CTRL_JUMP    = 8'b1001_1010;
    localparam logic [7:0] CTRL_BRANCH  = 8'b1000_0010;
    localparam logic [7:0] CTRL_LOAD    = 8'b1011_1100;
    localparam logic [7:0] CTRL_STORE   = 8'b1100_1000;
    localparam logic [7:0] CTRL_REG     = 8'b1001_0000;
    localparam logic [7:0] CTRL_ILLEGAL = 8'b1000_0001;

    // ctrl[7] doubles as the instrValid driven for the row
    typedef struct packed {
        logic [31:0]                instr;
        logic [31:0]                imm;
        logic [7:0]                 ctrl;
        decodeCtrlPkg::aluOp_e      aluOp;
        decodeCtrlPkg::aluCtrl_e    aluCtrl;
        decodeCtrlPkg::branchType_e branch;
    } rowEntry;

    logic                            clk;
    logic                            rst;
    logic [rvIsaPkg::XLEN-1:0]       instrIn;
    logic                            instrValid;
    logic [rvIsaPkg::XLEN-1:0]       rsValue1In;
    logic [rvIsaPkg::XLEN-1:0]       rsValue2In;
    logic [rvIsaPkg::REG_ADDR_W-1:0] rs1;
    logic [rvIsaPkg::REG_ADDR_W-1:0] rs2;
    logic [rvIsaPkg::REG_ADDR_W-1:0] rd;
    logic [rvIsaPkg::XLEN-1:0]       imm;
    logic [rvIsaPkg::XLEN-1:0]       value1;
    logic [rvIsaPkg::XLEN-1:0]       value2;
    logic                            decValid;
    logic                            memWrite;
    logic                            memRead;
    logic                            regWrite;
    logic                            aluSrc;
    logic                            memToReg;
    logic                            pcSrc;
    logic                            illegal;
    decodeCtrlPkg::aluOp_e           aluOp;
    decodeCtrlPkg::aluCtrl_e         aluCtrl;
    decodeCtrlPkg::branchType_e      branchType;
    logic [7:0]                      ctrlBits;

    rowEntry     rows[$];
    logic [31:0] seed = 32'h8df;
    int          errorCount = 0;
    int          passCount = 0;
    int          failCount = 0;
    int          cycleCount = 0;
    int          cycleLimit = RESET_CYCLES + MARGIN;
    int          rowStart;

    assign ctrlBits = {decValid, memWrite, memRead, regWrite, aluSrc, memToReg, pcSrc, illegal};

    decodeTop dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount > cycleLimit)
        begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcgNext();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [4:0] randReg();
        logic [31:0] r;
        r = lcgNext();
        return r[24:20];
    endfunction

    // Instruction encoders per ISA format with random register fields
    function automatic logic [31:0] encR(logic [6:0] f7, logic [2:0] f3);
        return {f7, randReg(), randReg(), f3, randReg(), rvIsaPkg::OP_REG};
    endfunction

    function automatic logic [31:0] encI(logic [31:0] immVal, logic [2:0] f3, logic [6:0] op);
        return {immVal[11:0], randReg(), f3, randReg(), op};
    endfunction

    function automatic logic [31:0] encS(logic [31:0] immVal, logic [2:0] f3);
        return {immVal[11:5], randReg(), randReg(), f3, immVal[4:0], rvIsaPkg::OP_STORE};
    endfunction

    function automatic logic [31:0] encB(logic [31:0] immVal, logic [2:0] f3);
        return {immVal[12], immVal[10:5], randReg(), randReg(), f3, immVal[4:1], immVal[11],
                rvIsaPkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] encU(logic [31:0] immVal, logic [6:0] op);
        return {immVal[31:12], randReg(), op};
    endfunction

    function automatic logic [31:0] encJ(logic [31:0] immVal);
        return {immVal[20], immVal[10:1], immVal[11], immVal[19:12], randReg(), rvIsaPkg::OP_JAL};
    endfunction

    task automatic addRow(input logic [31:0] instr, input logic [31:0] immVal,
                          input logic [7:0] ctrl, input decodeCtrlPkg::aluOp_e op,
                          input decodeCtrlPkg::aluCtrl_e alu,
                          input decodeCtrlPkg::branchType_e br);
        rows.push_back(rowEntry'{instr, immVal, ctrl, op, alu, br});
    endtask

    task automatic addOp(input logic [6:0] f7, input logic [2:0] f3,
                         input decodeCtrlPkg::aluCtrl_e alu);
        addRow(encR(f7, f3), 0, CTRL_REG, decodeCtrlPkg::ALUOP_ARITH, alu, decodeCtrlPkg::BR_BEQ);
    endtask

    task automatic addOpImm(input logic [31:0] immVal, input logic [2:0] f3,
                            input decodeCtrlPkg::aluCtrl_e alu);
        addRow(encI(immVal, f3, rvIsaPkg::OP_IMM), immVal, CTRL_WR_IMM,
               decodeCtrlPkg::ALUOP_ARITH, alu, decodeCtrlPkg::BR_BEQ);
    endtask

    task automatic addBranch(input logic [2:0] f3, input logic [31:0] immVal,
                             input decodeCtrlPkg::branchType_e br);
        addRow(encB(immVal, f3), immVal, CTRL_BRANCH, decodeCtrlPkg::ALUOP_BRANCH,
               decodeCtrlPkg::ALU_SUB, br);
    endtask

    task automatic addPlain(input logic [31:0] instr, input logic [31:0] immVal,
                            input logic [7:0] ctrl, input decodeCtrlPkg::aluOp_e op);
        addRow(instr, immVal, ctrl, op, decodeCtrlPkg::ALU_ADD, decodeCtrlPkg::BR_BEQ);
    endtask

    task automatic buildTable();
        // OP base and alternate groups
        addOp(7'h00, 3'b000, decodeCtrlPkg::ALU_ADD);
        addOp(7'h20, 3'b000, decodeCtrlPkg::ALU_SUB);
        addOp(7'h00, 3'b001, decodeCtrlPkg::ALU_SLL);
        addOp(7'h00, 3'b010, decodeCtrlPkg::ALU_SLT);
        addOp(7'h00, 3'b011, decodeCtrlPkg::ALU_SLTU);
        addOp(7'h00, 3'b100, decodeCtrlPkg::ALU_XOR);
        addOp(7'h00, 3'b101, decodeCtrlPkg::ALU_SRL);
        addOp(7'h20, 3'b101, decodeCtrlPkg::ALU_SRA);
        addOp(7'h00, 3'b110, decodeCtrlPkg::ALU_OR);
        addOp(7'h00, 3'b111, decodeCtrlPkg::ALU_AND);
        addOp(7'h20, 3'b111, decodeCtrlPkg::ALU_ADD);
        // M extension
        addOp(7'h01, 3'b000, decodeCtrlPkg::ALU_MUL);
        addOp(7'h01, 3'b001, decodeCtrlPkg::ALU_MULH);
        addOp(7'h01, 3'b010, decodeCtrlPkg::ALU_MULHSU);
        addOp(7'h01, 3'b011, decodeCtrlPkg::ALU_MULHU);
        addOp(7'h01, 3'b100, decodeCtrlPkg::ALU_DIV);
        addOp(7'h01, 3'b101, decodeCtrlPkg::ALU_DIVU);
        addOp(7'h01, 3'b110, decodeCtrlPkg::ALU_REM);
        addOp(7'h01, 3'b111, decodeCtrlPkg::ALU_REMU);
        // OP-IMM with funct7 of the shifts in the upper immediate bits
        addOpImm(5, 3'b000, decodeCtrlPkg::ALU_ADD);
        addOpImm(-1, 3'b000, decodeCtrlPkg::ALU_ADD);
        addOpImm(-2048, 3'b010, decodeCtrlPkg::ALU_SLT);
        addOpImm(100, 3'b011, decodeCtrlPkg::ALU_SLTU);
        addOpImm(-7, 3'b100, decodeCtrlPkg::ALU_XOR);
        addOpImm(2047, 3'b110, decodeCtrlPkg::ALU_OR);
        addOpImm(240, 3'b111, decodeCtrlPkg::ALU_AND);
        addOpImm({20'b0, 7'h00, 5'd3}, 3'b001, decodeCtrlPkg::ALU_SLL);
        addOpImm({20'b0, 7'h00, 5'd7}, 3'b101, decodeCtrlPkg::ALU_SRL);
        addOpImm({20'b0, 7'h20, 5'd9}, 3'b101, decodeCtrlPkg::ALU_SRA);
        // Loads and stores
        addPlain(encI(-16, 3'b010, rvIsaPkg::OP_LOAD), -16, CTRL_LOAD,
                 decodeCtrlPkg::ALUOP_MEMORY);
        addPlain(encI(12, 3'b100, rvIsaPkg::OP_LOAD), 12, CTRL_LOAD, decodeCtrlPkg::ALUOP_MEMORY);
        addPlain(encS(-4, 3'b010), -4, CTRL_STORE, decodeCtrlPkg::ALUOP_MEMORY);
        addPlain(encS(2047, 3'b000), 2047, CTRL_STORE, decodeCtrlPkg::ALUOP_MEMORY);
        // Branches at both ends of the B range
        addBranch(3'b000, -8, decodeCtrlPkg::BR_BEQ);
        addBranch(3'b001, 16, decodeCtrlPkg::BR_BNE);
        addBranch(3'b100, -4096, decodeCtrlPkg::BR_BLT);
        addBranch(3'b101, 4094, decodeCtrlPkg::BR_BGE);
        addBranch(3'b110, 2, decodeCtrlPkg::BR_BLTU);
        addBranch(3'b111, -2, decodeCtrlPkg::BR_BGEU);
        // Upper immediates and jumps
        addPlain(encU(32'hABCDE000, rvIsaPkg::OP_LUI), 32'hABCDE000, CTRL_WR_IMM,
                 decodeCtrlPkg::ALUOP_LUI);
        addPlain(encU(32'h80001000, rvIsaPkg::OP_AUIPC), 32'h80001000, CTRL_WR_IMM,
                 decodeCtrlPkg::ALUOP_AUIPC);
        addPlain(encJ(32'h000FFFFE), 32'h000FFFFE, CTRL_JUMP, decodeCtrlPkg::ALUOP_JUMP);
        addPlain(encJ(32'hFFF00000), 32'hFFF00000, CTRL_JUMP, decodeCtrlPkg::ALUOP_JUMP);
        addPlain(encI(-12, 3'b000, rvIsaPkg::OP_JALR), -12, CTRL_JUMP, decodeCtrlPkg::ALUOP_JALR);
        // SYSTEM and FENCE opcodes are outside the decoded set
        addPlain(encU(lcgNext(), 7'b1110011), 0, CTRL_ILLEGAL, decodeCtrlPkg::ALUOP_MEMORY);
        addPlain(encU(lcgNext(), 7'b0001111), 0, CTRL_ILLEGAL, decodeCtrlPkg::ALUOP_MEMORY);
        // Bubbles
        addRow(encR(7'h00, 3'b000), 0, CTRL_IDLE, decodeCtrlPkg::ALUOP_MEMORY,
               decodeCtrlPkg::ALU_AND, decodeCtrlPkg::BR_BEQ);
        addRow(encB(-8, 3'b001), 0, CTRL_IDLE, decodeCtrlPkg::ALUOP_MEMORY,
               decodeCtrlPkg::ALU_AND, decodeCtrlPkg::BR_BEQ);
    endtask

    task automatic checkWord(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            errorCount++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkCtrl(input string what, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            errorCount++;
            $display("ERR %0t: %s controls are %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkAluOp(input decodeCtrlPkg::aluOp_e got, input decodeCtrlPkg::aluOp_e exp);
        if (got !== exp)
        begin
            errorCount++;
            $display("ERR %0t: aluOp is %s, expected %s", $time, got.name(), exp.name());
        end
    endtask

    task automatic checkAluCtrl(input decodeCtrlPkg::aluCtrl_e got,
                                input decodeCtrlPkg::aluCtrl_e exp);
        if (got !== exp)
        begin
            errorCount++;
            $display("ERR %0t: aluCtrl is %s, expected %s", $time, got.name(), exp.name());
        end
    endtask

    task automatic checkBranch(input decodeCtrlPkg::branchType_e got,
                               input decodeCtrlPkg::branchType_e exp);
        if (got !== exp)
        begin
            errorCount++;
            $display("ERR %0t: branchType is %s, expected %s", $time, got.name(), exp.name());
        end
    endtask

    // Inputs still hold the row that was registered one edge earlier
    task automatic checkRow(input rowEntry e);
        checkCtrl("row", ctrlBits, e.ctrl);
        checkWord("imm", imm, e.imm);
        checkWord("value1", value1, rsValue1In);
        checkWord("value2", value2, rsValue2In);
        checkWord("rs1/rs2/rd", {17'b0, rs1, rs2, rd},
                  {17'b0, e.instr[19:15], e.instr[24:20], e.instr[11:7]});
        checkAluOp(aluOp, e.aluOp);
        checkAluCtrl(aluCtrl, e.aluCtrl);
        checkBranch(branchType, e.branch);
    endtask

    task automatic reportTest(input string name, input int startErrors);
        if (errorCount == startErrors)
        begin
            passCount++;
            $display("%s: ok", name);
        end
        else
        begin
            failCount++;
            $display("%s: %0d mismatches", name, errorCount - startErrors);
        end
    endtask

    initial
    begin
        clk        = 1'b0;
        rst        = 1'b1;
        // A valid load waits at the inputs while reset holds the register clear
        instrIn    = encI(-16, 3'b010, rvIsaPkg::OP_LOAD);
        instrValid = 1'b1;
        rsValue1In = lcgNext();
        rsValue2In = lcgNext();
        buildTable();
        cycleLimit = RESET_CYCLES + rows.size() + MARGIN;

        // Reset and the first idle cycle after it
        for (int i = 0; i <= RESET_CYCLES; i++)
        begin
            @(negedge clk);
            checkCtrl("reset", ctrlBits, CTRL_IDLE);
            checkWord("reset imm", imm, 32'h0);
            checkWord("reset value1", value1, 32'h0);
            checkWord("reset value2", value2, 32'h0);
            checkAluOp(aluOp, decodeCtrlPkg::ALUOP_MEMORY);
            checkAluCtrl(aluCtrl, decodeCtrlPkg::ALU_AND);
            checkBranch(branchType, decodeCtrlPkg::BR_BEQ);
            if (i == RESET_CYCLES - 1)
            begin
                rst        = 1'b0;
                instrIn    = 32'h0;
                instrValid = 1'b0;
                rsValue1In = 32'h0;
                rsValue2In = 32'h0;
            end
        end
        reportTest("reset state", 0);

        // Back-to-back rows each checked one edge after it was driven
        for (int i = 0; i <= rows.size(); i++)
        begin
            if (i > 0)
            begin
                @(negedge clk);
                rowStart = errorCount;
                checkRow(rows[i - 1]);
                reportTest($sformatf("row %0d instr %h", i - 1, rows[i - 1].instr), rowStart);
            end
            if (i < rows.size())
            begin
                instrIn    = rows[i].instr;
                instrValid = rows[i].ctrl[7];
                rsValue1In = lcgNext();
                rsValue2In = lcgNext();
            end
        end

        $display("Tests: %0d passed, %0d failed, %0d mismatches", passCount, failCount, errorCount);
        if (errorCount == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- rvDecode.f
rtl/rvIsaPkg.sv
rtl/decodeCtrlPkg.sv
rtl/decodeRegister.sv
rtl/mainControl.sv
rtl/immGen.sv
rtl/aluControl.sv
rtl/decodeTop.sv
sim/decodeTop_props.sv
sim/decodeTb.sv

//--- Makefile
# Verilator build and run of the decode stage testbench
VERILATOR ?= verilator
TOP       ?= decodeTb
FILELIST  ?= rvDecode.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  := Simulation completed successfully

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
